/* vlog.f */
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/pattern_gen.sv
verilog/osd_window.sv
verilog/video_top.sv
dv/video_asserts.sv
dv/video_checker.sv
dv/video_tb.sv

/* Bender.yml */
package:
  name: video_osd

sources:
  - verilog/video_pkg.sv
  - verilog/video_timing.sv
  - verilog/pattern_gen.sv
  - verilog/osd_window.sv
  - verilog/video_top.sv
  - target: simulation
    files:
      - dv/video_asserts.sv
      - dv/video_checker.sv
      - dv/video_tb.sv

/* dv/video_tb.sv */
// Small 64x32 timing so frames are short; mode changes are only driven while o_blank is low.
`default_nettype none

module video_tb
  import video_pkg::*;
();

  localparam int H_ACTIVE   = 64;
  localparam int H_FRONT    = 4;
  localparam int H_SYNC     = 8;
  localparam int H_BACK     = 8;
  localparam int V_ACTIVE   = 32;
  localparam int V_FRONT    = 4;
  localparam int V_SYNC     = 2;
  localparam int V_BACK     = 8;
  localparam int X_START    = 16;
  localparam int X_STOP     = 48;
  localparam int Y_START    = 8;
  localparam int Y_STOP     = 24;
  localparam int WAIT_LIMIT = 20000; // Enabled or not, about four frames of cycles.

  logic               clk_pixel = 1'b0;
  logic               i_reset;
  logic               i_pixel_ena;
  osd_mode_e          i_osd_mode;
  logic [PIXEL_W-1:0] o_r;
  logic [PIXEL_W-1:0] o_g;
  logic [PIXEL_W-1:0] o_b;
  logic               o_hsync;
  logic               o_vsync;
  logic               o_blank;
  int                 chk_checks;
  int                 chk_errors;
  logic [31:0]        rnd_state = 32'ha095;
  bit                 gaps = 1'b0;
  bit                 timed_out = 1'b0;

  always #50 clk_pixel = ~clk_pixel;

  video_top #(
    .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
    .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
    .X_START  (X_START),  .X_STOP  (X_STOP),  .Y_START (Y_START), .Y_STOP (Y_STOP)
  ) i_video_top (
    .i_reset (i_reset), .clk_pixel (clk_pixel), .i_pixel_ena (i_pixel_ena),
    .i_osd_mode (i_osd_mode), .o_r (o_r), .o_g (o_g), .o_b (o_b),
    .o_hsync (o_hsync), .o_vsync (o_vsync), .o_blank (o_blank)
  );

  video_checker #(
    .H_ACTIVE (H_ACTIVE), .V_ACTIVE (V_ACTIVE),
    .X_START  (X_START),  .X_STOP  (X_STOP), .Y_START (Y_START), .Y_STOP (Y_STOP)
  ) i_video_checker (
    .i_reset (i_reset), .clk_pixel (clk_pixel), .i_pixel_ena (i_pixel_ena),
    .i_osd_mode (i_osd_mode), .i_r (o_r), .i_g (o_g), .i_b (o_b),
    .i_hsync (o_hsync), .i_vsync (o_vsync), .i_blank (o_blank),
    .o_checks (chk_checks), .o_errors (chk_errors)
  );

  function automatic logic [31:0] next_random();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
    return rnd_state;
  endfunction

  // One falling edge; the enable drops on about a quarter of cycles when gaps is set.
  task automatic step();
    logic [31:0] rnd;
    @(negedge clk_pixel);
    rnd = next_random();
    i_pixel_ena = gaps ? (rnd[31:30] != 2'b00) : 1'b1;
  endtask

  task automatic wait_sync_rise(input bit use_h);
    int   n;
    logic prev;
    logic cur;
    logic seen;
    n = 0;
    prev = use_h ? o_hsync : o_vsync;
    cur = prev;
    while (!(cur && !prev) && n < WAIT_LIMIT && !timed_out)
    begin
      step();
      prev = cur;
      cur = use_h ? o_hsync : o_vsync;
      n++;
    end
    // The checker sees the rise one enabled edge later.
    seen = 1'b0;
    while (!seen && n < WAIT_LIMIT && !timed_out)
    begin
      seen = i_pixel_ena;
      step();
      n++;
    end
    if (n >= WAIT_LIMIT)
    begin
      timed_out = 1'b1;
      $display("Timeout: no %s rise within %0d cycles", use_h ? "hsync" : "vsync", n);
    end
  endtask

  task automatic set_mode_mid_frame(input osd_mode_e mode);
    int n;
    n = 0;
    while (o_blank && n < WAIT_LIMIT && !timed_out)
    begin
      step();
      n++;
    end
    if (n >= WAIT_LIMIT)
    begin
      timed_out = 1'b1;
      $display("Timeout: blank never went low within %0d cycles", n);
    end
    i_osd_mode = mode;
  endtask

  task automatic run_frames(input osd_mode_e mode);
    set_mode_mid_frame(mode);
    wait_sync_rise(1'b0); // The new mode is latched here.
    wait_sync_rise(1'b0);
  endtask

  initial
  begin
    logic [31:0] rnd;
    logic [1:0]  code;
    int          total_errors;
    i_reset = 1'b1;
    i_pixel_ena = 1'b1;
    i_osd_mode = MODE_OFF;
    repeat (3) @(negedge clk_pixel);
    i_reset = 1'b0;
    i_video_checker.print_test("reset state");
    run_frames(MODE_OFF);
    i_video_checker.print_test("mode off, full frame");
    run_frames(MODE_BLUE);
    run_frames(MODE_INVERT);
    i_video_checker.print_test("blue and invert");
    gaps = 1'b1;
    run_frames(MODE_TINT);
    i_video_checker.print_test("tint with enable gaps");
    repeat (3)
    begin
      // Vsync, back porch and twelve active rows put the change inside the window.
      repeat (V_SYNC + V_BACK + 12) wait_sync_rise(1'b1);
      rnd = next_random();
      code = rnd[25:24];
      if (code == i_osd_mode)
        code = code + 2'd1;
      run_frames(osd_mode_e'(code));
    end
    i_video_checker.print_test("mid-frame mode change");
    total_errors = chk_errors + i_video_top.i_video_asserts.fail_count;
    $display("Totals: %0d checks, %0d errors, %0d timeouts", chk_checks, total_errors,
             timed_out);
    if (timed_out || total_errors != 0)
      $display("=== FAIL ===");
    else
      $display("=== PASS ===");
    $finish;
  end

endmodule : video_tb

`default_nettype wire

/* dv/video_checker.sv */
// Model of the output stream; expects a full frame to start the count, mode is sampled at the o_vsync rise.
`default_nettype none

module video_checker
  import video_pkg::*;
#(
  parameter int H_ACTIVE = 64,
  parameter int V_ACTIVE = 32,
  parameter int X_START  = 16,
  parameter int X_STOP   = 48,
  parameter int Y_START  = 8,
  parameter int Y_STOP   = 24
)
(
  input  logic               i_reset,
  input  logic               clk_pixel,
  input  logic               i_pixel_ena,
  input  osd_mode_e          i_osd_mode,
  input  logic [PIXEL_W-1:0] i_r,
  input  logic [PIXEL_W-1:0] i_g,
  input  logic [PIXEL_W-1:0] i_b,
  input  logic               i_hsync,
  input  logic               i_vsync,
  input  logic               i_blank,
  output int                 o_checks,
  output int                 o_errors
);

  localparam logic [PIXEL_W-1:0] FULL = {PIXEL_W{1'b1}};

  logic                   rst_q = 1'b0;
  logic                   hs_q;
  logic                   vs_q;
  int                     col;
  int                     row;
  int                     frame_pix;
  osd_mode_e              mode_m;
  logic [3*PIXEL_W-1:0]   exp_rgb;
  int                     base_checks = 0;
  int                     base_errors = 0;

  initial
  begin
    o_checks = 0;
    o_errors = 0;
  end

  // Test pattern at active column x and row y, then the window recolor.
  function automatic logic [3*PIXEL_W-1:0] expected_pixel(int x, int y, osd_mode_e mode);
    logic [PIXEL_W-1:0] r;
    logic [PIXEL_W-1:0] g;
    logic [PIXEL_W-1:0] b;
    r = PIXEL_W'(x * 4);
    g = PIXEL_W'(y * 8);
    b = PIXEL_W'(x ^ y);
    if (x >= X_START && x < X_STOP && y >= Y_START && y < Y_STOP)
    begin
      case (mode)
        MODE_BLUE:   b = FULL;
        MODE_INVERT:
        begin
          r = FULL - r;
          g = FULL - g;
          b = FULL - b;
        end
        MODE_TINT:
        begin
          r = r / 2;
          g = g / 2;
          b = FULL;
        end
        default:     ;
      endcase
    end
    return {r, g, b};
  endfunction

  task automatic report_error(input string msg);
    o_errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic print_test(input string name);
    $display("Test %s: %0d checks, %0d errors", name, o_checks - base_checks,
             o_errors - base_errors);
    base_checks = o_checks;
    base_errors = o_errors;
  endtask

  always @(posedge clk_pixel)
  begin
    rst_q <= i_reset;
    if (i_reset)
    begin
      if (rst_q) // Outputs have seen one reset edge by now.
      begin
        o_checks++;
        if (i_hsync !== 1'b0 || i_vsync !== 1'b0 || i_blank !== 1'b1)
          report_error("sync or blank wrong while reset is held");
      end
      hs_q      <= 1'b0;
      vs_q      <= 1'b0;
      col       <= 0;
      row       <= 0;
      frame_pix <= 0;
      mode_m    <= MODE_OFF;
    end
    else if (i_pixel_ena)
    begin
      hs_q <= i_hsync;
      vs_q <= i_vsync;
      if (i_vsync && !vs_q)
      begin
        mode_m    <= i_osd_mode;
        row       <= 0;
        frame_pix <= 0;
        o_checks++;
        if (frame_pix != H_ACTIVE * V_ACTIVE || row != V_ACTIVE)
          report_error($sformatf("frame had %0d pixels in %0d rows", frame_pix, row));
      end
      if (i_hsync && !hs_q)
      begin
        col <= 0;
        if (col != 0)
        begin
          o_checks++;
          row <= row + 1;
          if (col != H_ACTIVE)
            report_error($sformatf("row %0d had %0d pixels", row, col));
        end
      end
      if (!i_blank)
      begin
        exp_rgb = expected_pixel(col, row, mode_m);
        o_checks++;
        col       <= col + 1;
        frame_pix <= frame_pix + 1;
        if ({i_r, i_g, i_b} !== exp_rgb)
          report_error($sformatf("pixel (%0d,%0d) %s got %h expected %h", col, row,
                                 mode_m.name(), {i_r, i_g, i_b}, exp_rgb));
      end
    end
  end

endmodule : video_checker

`default_nettype wire

/* dv/video_asserts.sv */
// Pulse width counts enabled cycles only; all properties are off while i_reset is high.
`default_nettype none

module video_asserts
  import video_pkg::*;
#(
  parameter int H_SYNC = 8
)
(
  input logic               i_reset,
  input logic               clk_pixel,
  input logic               i_pixel_ena,
  input logic               i_hsync,
  input logic               i_vsync,
  input logic               i_blank,
  input logic [PIXEL_W-1:0] i_r,
  input logic [PIXEL_W-1:0] i_g,
  input logic [PIXEL_W-1:0] i_b
);

  int unsigned hsync_len;
  int unsigned fail_count = 0;

  always @(posedge clk_pixel)
  begin
    if (i_reset)
      hsync_len <= 0;
    else if (i_pixel_ena)
      hsync_len <= i_hsync ? hsync_len + 1 : 0; // Length of the pulse so far.
  end

  sync_in_blank: assert property (@(posedge clk_pixel) disable iff (i_reset)
    (i_hsync || i_vsync) |-> i_blank)
  else
  begin
    fail_count++;
    $error("sync high during active video");
  end

  hsync_width: assert property (@(posedge clk_pixel) disable iff (i_reset)
    (i_pixel_ena && !i_hsync && hsync_len != 0) |-> (hsync_len == H_SYNC))
  else
  begin
    fail_count++;
    $error("hsync pulse of %0d enabled cycles", $sampled(hsync_len));
  end

  // Blanked pixels carry no color.
  blank_black: assert property (@(posedge clk_pixel) disable iff (i_reset)
    i_blank |-> ({i_r, i_g, i_b} == '0))
  else
  begin
    fail_count++;
    $error("color present during blank");
  end

endmodule : video_asserts

bind video_top video_asserts #(.H_SYNC(H_SYNC)) i_video_asserts (
  .i_reset     (i_reset),
  .clk_pixel   (clk_pixel),
  .i_pixel_ena (i_pixel_ena),
  .i_hsync     (o_hsync),
  .i_vsync     (o_vsync),
  .i_blank     (o_blank),
  .i_r         (o_r),
  .i_g         (o_g),
  .i_b         (o_b)
);

`default_nettype wire

/* verilog/video_top.sv */
// Timing, pattern and OSD stages in a chain; three enabled cycles from counters to outputs, no back-pressure.
`default_nettype none

module video_top
  import video_pkg::*;
#(
  parameter int H_ACTIVE = 64,
  parameter int H_FRONT  = 4,
  parameter int H_SYNC   = 8,
  parameter int H_BACK   = 8,
  parameter int V_ACTIVE = 32,
  parameter int V_FRONT  = 4,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 8,
  parameter int X_START  = 16,
  parameter int X_STOP   = 48,
  parameter int Y_START  = 8,
  parameter int Y_STOP   = 24
)
(
  input  logic               i_reset,
  input  logic               clk_pixel,
  input  logic               i_pixel_ena,
  input  osd_mode_e          i_osd_mode,
  output logic [PIXEL_W-1:0] o_r,
  output logic [PIXEL_W-1:0] o_g,
  output logic [PIXEL_W-1:0] o_b,
  output logic               o_hsync,
  output logic               o_vsync,
  output logic               o_blank
);

  logic               tim_hsync;
  logic               tim_vsync;
  logic               tim_blank;
  logic [COORD_W-1:0] tim_x;
  logic [COORD_W-1:0] tim_y;
  logic [PIXEL_W-1:0] pat_r;
  logic [PIXEL_W-1:0] pat_g;
  logic [PIXEL_W-1:0] pat_b;
  logic               pat_hsync;
  logic               pat_vsync;
  logic               pat_blank;

  video_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) i_video_timing (
    .i_reset     (i_reset),
    .clk_pixel   (clk_pixel),
    .i_pixel_ena (i_pixel_ena),
    .o_hsync     (tim_hsync),
    .o_vsync     (tim_vsync),
    .o_blank     (tim_blank),
    .o_x         (tim_x),
    .o_y         (tim_y)
  );

  pattern_gen i_pattern_gen (
    .i_reset     (i_reset),
    .clk_pixel   (clk_pixel),
    .i_pixel_ena (i_pixel_ena),
    .i_hsync     (tim_hsync),
    .i_vsync     (tim_vsync),
    .i_blank     (tim_blank),
    .i_x         (tim_x),
    .i_y         (tim_y),
    .o_r         (pat_r),
    .o_g         (pat_g),
    .o_b         (pat_b),
    .o_hsync     (pat_hsync),
    .o_vsync     (pat_vsync),
    .o_blank     (pat_blank)
  );

  osd_window #(
    .X_START (X_START),
    .X_STOP  (X_STOP),
    .Y_START (Y_START),
    .Y_STOP  (Y_STOP)
  ) i_osd_window (
    .i_reset     (i_reset),
    .clk_pixel   (clk_pixel),
    .i_pixel_ena (i_pixel_ena),
    .i_osd_mode  (i_osd_mode),
    .i_r         (pat_r),
    .i_g         (pat_g),
    .i_b         (pat_b),
    .i_hsync     (pat_hsync),
    .i_vsync     (pat_vsync),
    .i_blank     (pat_blank),
    .o_r         (o_r),
    .o_g         (o_g),
    .o_b         (o_b),
    .o_hsync     (o_hsync),
    .o_vsync     (o_vsync),
    .o_blank     (o_blank)
  );

endmodule : video_top

`default_nettype wire

/* verilog/osd_window.sv */
// Window position is recovered from sync and blank only; mode is latched at the vsync rise and holds one frame.
`default_nettype none

module osd_window
  import video_pkg::*;
#(
  parameter int X_START = 16,
  parameter int X_STOP  = 48,
  parameter int Y_START = 8,
  parameter int Y_STOP  = 24
)
(
  input  logic               i_reset,
  input  logic               clk_pixel,
  input  logic               i_pixel_ena,
  input  osd_mode_e          i_osd_mode,
  input  logic [PIXEL_W-1:0] i_r,
  input  logic [PIXEL_W-1:0] i_g,
  input  logic [PIXEL_W-1:0] i_b,
  input  logic               i_hsync,
  input  logic               i_vsync,
  input  logic               i_blank,
  output logic [PIXEL_W-1:0] o_r,
  output logic [PIXEL_W-1:0] o_g,
  output logic [PIXEL_W-1:0] o_b,
  output logic               o_hsync,
  output logic               o_vsync,
  output logic               o_blank
);

  logic               hsync_prev;
  logic               vsync_prev;
  logic               line_active; // Current line has shown at least one pixel.
  logic [COORD_W-1:0] xcount;      // Unblanked pixels seen since the last hsync rise.
  logic [COORD_W-1:0] ycount;      // Active lines completed since vsync.
  osd_mode_e          mode_q;
  logic               hsync_rise;
  logic               vsync_rise;
  logic               osd_xen;
  logic               osd_yen;
  logic               osd_en;
  logic [PIXEL_W-1:0] next_r;
  logic [PIXEL_W-1:0] next_g;
  logic [PIXEL_W-1:0] next_b;

  assign hsync_rise = i_hsync & ~hsync_prev;
  assign vsync_rise = i_vsync & ~vsync_prev;

  // The counters already hold the position of the pixel now at the input.
  assign osd_xen = (xcount >= X_START) && (xcount < X_STOP);
  assign osd_yen = (ycount >= Y_START) && (ycount < Y_STOP);
  assign osd_en  = osd_xen & osd_yen & ~i_blank;

  always_ff @(posedge clk_pixel)
  begin
    if (i_reset)
    begin
      hsync_prev  <= 1'b0;
      vsync_prev  <= 1'b0;
      line_active <= 1'b0;
      xcount      <= '0;
      ycount      <= '0;
      mode_q      <= MODE_OFF;
    end
    else if (i_pixel_ena)
    begin
      hsync_prev <= i_hsync;
      vsync_prev <= i_vsync;
      if (vsync_rise)
        mode_q <= i_osd_mode; // Takes effect from the next active line.
      if (hsync_rise)
      begin
        xcount      <= '0;
        line_active <= 1'b0;
        if (i_vsync)
          ycount <= '0;
        else if (line_active)
          ycount <= ycount + 1'b1;
      end
      else
      begin
        if (i_vsync)
          ycount <= '0;
        if (!i_blank)
        begin
          xcount      <= xcount + 1'b1;
          line_active <= 1'b1;
        end
      end
    end
  end

  always_comb
  begin
    next_r = i_r;
    next_g = i_g;
    next_b = i_b;
    if (osd_en)
    begin
      case (mode_q)
        MODE_BLUE:   next_b = {PIXEL_W{1'b1}};
        MODE_INVERT:
        begin
          next_r = ~i_r;
          next_g = ~i_g;
          next_b = ~i_b;
        end
        MODE_TINT:
        begin
          next_r = i_r >> 1;
          next_g = i_g >> 1;
          next_b = {PIXEL_W{1'b1}};
        end
        default:     ;
      endcase
    end
  end

  always_ff @(posedge clk_pixel)
  begin
    if (i_reset)
    begin
      o_r     <= '0;
      o_g     <= '0;
      o_b     <= '0;
      o_hsync <= 1'b0;
      o_vsync <= 1'b0;
      o_blank <= 1'b1;
    end
    else if (i_pixel_ena)
    begin
      o_r     <= next_r;
      o_g     <= next_g;
      o_b     <= next_b;
      o_hsync <= i_hsync;
      o_vsync <= i_vsync;
      o_blank <= i_blank;
    end
  end

endmodule : osd_window

`default_nettype wire

/* verilog/pattern_gen.sv */
// Test image from the coordinates only; colors are forced to zero while blanked, latency is one enabled cycle.
`default_nettype none

module pattern_gen
  import video_pkg::*;
(
  input  logic               i_reset,
  input  logic               clk_pixel,
  input  logic               i_pixel_ena,
  input  logic               i_hsync,
  input  logic               i_vsync,
  input  logic               i_blank,
  input  logic [COORD_W-1:0] i_x,
  input  logic [COORD_W-1:0] i_y,
  output logic [PIXEL_W-1:0] o_r,
  output logic [PIXEL_W-1:0] o_g,
  output logic [PIXEL_W-1:0] o_b,
  output logic               o_hsync,
  output logic               o_vsync,
  output logic               o_blank
);

  logic [PIXEL_W-1:0] pat_r;
  logic [PIXEL_W-1:0] pat_g;
  logic [PIXEL_W-1:0] pat_b;
  logic [COORD_W-1:0] xy_mix;

  assign xy_mix = i_x ^ i_y;

  // Ramps wrap every 64 columns and every 32 rows.
  assign pat_r = PIXEL_W'(i_x << 2);
  assign pat_g = PIXEL_W'(i_y << 3);
  assign pat_b = xy_mix[PIXEL_W-1:0];

  always_ff @(posedge clk_pixel)
  begin
    if (i_reset)
    begin
      o_r     <= '0;
      o_g     <= '0;
      o_b     <= '0;
      o_hsync <= 1'b0;
      o_vsync <= 1'b0;
      o_blank <= 1'b1;
    end
    else if (i_pixel_ena)
    begin
      o_hsync <= i_hsync;
      o_vsync <= i_vsync;
      o_blank <= i_blank;
      if (i_blank)
      begin
        o_r <= '0;
        o_g <= '0;
        o_b <= '0;
      end
      else
      begin
        o_r <= pat_r;
        o_g <= pat_g;
        o_b <= pat_b;
      end
    end
  end

endmodule : pattern_gen

`default_nettype wire

/* verilog/video_timing.sv */
// Line and frame order is active, front porch, sync, back porch; syncs active high, all outputs step on i_pixel_ena.
`default_nettype none

module video_timing
  import video_pkg::*;
#(
  parameter int H_ACTIVE = 64,
  parameter int H_FRONT  = 4,
  parameter int H_SYNC   = 8,
  parameter int H_BACK   = 8,
  parameter int V_ACTIVE = 32,
  parameter int V_FRONT  = 4,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 8
)
(
  input  logic               i_reset,
  input  logic               clk_pixel,
  input  logic               i_pixel_ena,
  output logic               o_hsync,
  output logic               o_vsync,
  output logic               o_blank,
  output logic [COORD_W-1:0] o_x,
  output logic [COORD_W-1:0] o_y
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

  logic [COORD_W-1:0] h_cnt;
  logic [COORD_W-1:0] v_cnt;
  logic               line_end;

  assign line_end = (h_cnt == H_TOTAL - 1);

  always_ff @(posedge clk_pixel)
  begin
    if (i_reset)
    begin
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else if (i_pixel_ena)
    begin
      if (line_end)
      begin
        h_cnt <= '0;
        if (v_cnt == V_TOTAL - 1)
          v_cnt <= '0; // Wrap to the first active line.
        else
          v_cnt <= v_cnt + 1'b1;
      end
      else
        h_cnt <= h_cnt + 1'b1;
    end
  end

  // Decode from the counter state and register, one enabled cycle behind the counters.
  always_ff @(posedge clk_pixel)
  begin
    if (i_reset)
    begin
      o_hsync <= 1'b0;
      o_vsync <= 1'b0;
      o_blank <= 1'b1;
      o_x     <= '0;
      o_y     <= '0;
    end
    else if (i_pixel_ena)
    begin
      o_hsync <= (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_START + H_SYNC);
      o_vsync <= (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_START + V_SYNC);
      o_blank <= (h_cnt >= H_ACTIVE) || (v_cnt >= V_ACTIVE);
      o_x     <= h_cnt;
      o_y     <= v_cnt;
    end
  end

endmodule : video_timing

`default_nettype wire

/* verilog/video_pkg.sv */
// Shared video widths and the overlay opcode; COORD_W must hold the full line and frame totals.
`default_nettype none

package video_pkg;

  // One color channel.
  localparam int PIXEL_W = 8;

  // Column and row counters, also used for the raw timing counters.
  localparam int COORD_W = 11;

  // Overlay mode applied inside the OSD window.
  // The value is latched by osd_window once per frame, at the vsync rise.
  typedef enum logic [1:0] {
    MODE_OFF    = 2'd0, // Pixels pass unchanged.
    MODE_BLUE   = 2'd1, // Blue forced to full scale.
    MODE_INVERT = 2'd2, // All three channels inverted.
    MODE_TINT   = 2'd3  // Red and green halved, blue forced to full scale.
  } osd_mode_e;

endpackage : video_pkg

`default_nettype wire
